/* src.f */
verilog/snes_mem_pkg.sv
verilog/sdram_req_if.sv
verilog/bus_phase_gate.sv
verilog/cpu_port_arbiter.sv
verilog/aux_port_ctrl.sv
verilog/snes_mem_bridge.sv
verification/tb_clock_gen.sv
verification/snes_mem_bridge_chk.sv
verification/snes_mem_bridge_tb.sv

/* Bender.yml */
package:
  name: snes_mem_bridge

sources:
  - files:
      - verilog/snes_mem_pkg.sv
      - verilog/sdram_req_if.sv
      - verilog/bus_phase_gate.sv
      - verilog/cpu_port_arbiter.sv
      - verilog/aux_port_ctrl.sv
      - verilog/snes_mem_bridge.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/snes_mem_bridge_chk.sv
      - verification/snes_mem_bridge_tb.sv

/* verification/snes_mem_bridge_tb.sv */
/* Random test of the SDRAM request bridge against a cycle model, fixed seed.
   SDRAM read data is random each cycle; no request is ever refused.
   Inputs change on the rising edge, everything is compared on the falling edge. */

`timescale 1ns/100ps

module snes_mem_bridge_tb;
    import snes_mem_pkg::*;

    localparam int STIM_CYCLES    = 4000;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    logic wclk;
    logic resetn;
    logic sysclkf_ce, sysclkr_ce, sdram_busy, loader_fail, frame_sync_pause, enable;
    logic loading, loader_do_valid, rom_ce_n, rom_word;
    logic wram_ce_n, wram_rd_n, wram_we_n, bsram_ce_n, bsram_rd_n, bsram_we_n;
    logic aram_ce_n, aram_oe_n, aram_we_n;
    logic [7:0] loader_do, wram_d, wram_q, rom_type, bsram_d, bsram_q, aram_d, aram_q;
    logic [ROM_AW-1:0] rom_addr;
    logic [WRAM_AW-1:0] wram_addr;
    logic [BSRAM_AW-1:0] bsram_addr, sd_bsram_addr;
    logic [ARAM_AW-1:0] aram_addr, sd_aram_addr;
    logic [ROM_AW-2:0] sd_cpu_addr;
    logic [15:0] rom_q, sd_cpu_din, sd_port0, sd_port1, sd_aram_din, sd_aram_dout;
    logic [1:0] sd_cpu_ds;
    logic sd_cpu_port, sd_cpu_rd, sd_cpu_wr, sd_bsram_rd, sd_bsram_wr, sd_aram_rd, sd_aram_wr;
    logic [7:0] sd_bsram_din, sd_bsram_dout;

    // model state and expected registered outputs
    logic m_en, m_f, m_r, m_load_r, m_lsb, model_valid;
    logic [ROM_AW-1:0] m_cnt;           // loader byte counter
    logic e_rd, e_wr, e_port, e_bs_rd, e_bs_wr, e_live;
    logic [1:0] e_ds;
    logic [ROM_AW-2:0] e_addr;
    logic [15:0] e_din;
    logic [BSRAM_AW-1:0] e_bs_addr;
    logic [7:0] e_bs_din, exp_wram, exp_aram;
    sdram_word_u exp_rom;
    integer seed;
    int cycle_cnt = 0;
    int load_left = 0;                  // cycles left in the loader burst

    tb_clock_gen i_tb_clock_gen (.wclk, .resetn);

    snes_mem_bridge i_snes_mem_bridge (.*);

    bind cpu_port_arbiter snes_mem_bridge_chk i_req_chk (
        .wclk, .resetn, .rd(req.rd), .wr(req.wr), .ds(req.ds)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("%s at %0t", what, $time);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic drive_inputs(input int cyc);
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        sysclkf_ce       <= r[0];
        sysclkr_ce       <= r[1];
        sdram_busy       <= (cyc < 40) || (r[6:2] == 0);    // controller init, then rare
        loader_fail      <= (r[11:7] == 0);
        frame_sync_pause <= (r[16:12] == 0);
        rom_ce_n         <= r[17];
        rom_word         <= r[18];
        wram_ce_n        <= r[19];
        wram_rd_n        <= r[20];
        wram_we_n        <= ~r[20];                          // one wram op at a time
        if (load_left > 0) begin
            load_left = load_left - 1;
            loading         <= 1'b1;
            loader_do_valid <= r[21];
        end else if (r[27:22] == 0) begin                   // burst about every 64 cycles
            load_left = 8 + r[31:28] * 4;
            loading         <= 1'b1;
            loader_do_valid <= 1'b0;                        // no byte on the first cycle
        end else begin
            loading         <= 1'b0;
            loader_do_valid <= 1'b0;
        end
        rom_type   <= {(s[1:0] == 0) ? SA1_TYPE_NIBBLE : s[5:2], s[9:6]};
        bsram_ce_n <= s[10];
        bsram_rd_n <= s[11];
        bsram_we_n <= s[12];
        aram_ce_n  <= s[13];
        aram_oe_n  <= s[14];
        aram_we_n  <= s[15];
        loader_do  <= s[23:16];
        wram_d     <= s[31:24];
        rom_addr   <= $random(seed);
        wram_addr  <= $random(seed);
        bsram_addr <= $random(seed);
        aram_addr  <= $random(seed);
        bsram_d    <= $random(seed);
        aram_d     <= $random(seed);
        sd_port0      <= $random(seed);     // sdram read data, any word
        sd_port1      <= $random(seed);
        sd_bsram_dout <= $random(seed);
        sd_aram_dout  <= $random(seed);
    endtask

    always @(posedge wclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            report_problem("run did not end within the cycle limit");
        end
    end

    always @(negedge wclk) begin
        if (cycle_cnt > 0) begin                            // wclk falls from x at time 0
            exp_rom.word = sd_port0;
            if (!rom_word && rom_addr[0]) begin
                exp_rom.word = {sd_port0[7:0], sd_port0[15:8]};  // odd byte moves down
            end
            exp_wram = wram_addr[0] ? sd_port1[15:8] : sd_port1[7:0];
            exp_aram = m_lsb ? sd_aram_dout[15:8] : sd_aram_dout[7:0];
            if (model_valid) begin
                assert (rom_q === exp_rom) else report_mismatch("rom_q", rom_q, exp_rom);
                assert (wram_q === exp_wram)
                    else report_mismatch("wram_q", wram_q, exp_wram);
                assert (aram_q === exp_aram)
                    else report_mismatch("aram_q", aram_q, exp_aram);
                assert (bsram_q === sd_bsram_dout)
                    else report_mismatch("bsram_q", bsram_q, sd_bsram_dout);
                assert (sd_aram_rd === (!aram_ce_n && !aram_oe_n))
                    else report_mismatch("sd_aram_rd", sd_aram_rd, !aram_ce_n && !aram_oe_n);
                assert (sd_aram_wr === (!aram_ce_n && !aram_we_n))
                    else report_mismatch("sd_aram_wr", sd_aram_wr, !aram_ce_n && !aram_we_n);
                assert (sd_aram_addr === aram_addr)
                    else report_mismatch("sd_aram_addr", sd_aram_addr, aram_addr);
                assert (sd_aram_din === {aram_d, aram_d})
                    else report_mismatch("sd_aram_din", sd_aram_din, {aram_d, aram_d});
                assert (enable === m_en) else report_mismatch("enable", enable, m_en);
                assert (sd_cpu_rd === e_rd)
                    else report_mismatch("sd_cpu_rd", sd_cpu_rd, e_rd);
                assert (sd_cpu_wr === e_wr)
                    else report_mismatch("sd_cpu_wr", sd_cpu_wr, e_wr);
                assert (sd_cpu_ds === e_ds)
                    else report_mismatch("sd_cpu_ds", sd_cpu_ds, e_ds);
                assert (sd_cpu_port === e_port)
                    else report_mismatch("sd_cpu_port", sd_cpu_port, e_port);
                if (e_live) begin                           // addr and din are not reset
                    assert (sd_cpu_addr === e_addr)
                        else report_mismatch("sd_cpu_addr", sd_cpu_addr, e_addr);
                    assert (sd_cpu_din === e_din)
                        else report_mismatch("sd_cpu_din", sd_cpu_din, e_din);
                end
                assert (sd_bsram_rd === e_bs_rd)
                    else report_mismatch("sd_bsram_rd", sd_bsram_rd, e_bs_rd);
                assert (sd_bsram_wr === e_bs_wr)
                    else report_mismatch("sd_bsram_wr", sd_bsram_wr, e_bs_wr);
                assert (sd_bsram_addr === e_bs_addr)
                    else report_mismatch("sd_bsram_addr", sd_bsram_addr, e_bs_addr);
                assert (sd_bsram_din === e_bs_din)
                    else report_mismatch("sd_bsram_din", sd_bsram_din, e_bs_din);
                assert (i_snes_mem_bridge.i_cpu_port_arbiter.i_req_chk.fail_cnt == 0)
                    else report_problem("a bound request assertion failed");
            end

            // next edge, from the inputs now on the bus
            e_bs_addr = bsram_addr;                         // no reset on these
            e_bs_din  = bsram_d;
            if (!resetn) begin
                {m_en, m_f, m_r, m_load_r, m_lsb} = '0;
                {e_rd, e_wr, e_port, e_bs_rd, e_bs_wr} = '0;
                e_live = 1'b0;
                e_ds   = 2'b00;
                m_cnt  = '0;
            end else begin
                {e_rd, e_wr, e_port} = '0;
                e_live = 1'b1;
                e_ds   = 2'b00;
                e_addr = '0;
                e_din  = '0;
                if (loading && loader_do_valid) begin       // loader wins
                    e_wr   = 1'b1;
                    e_addr = m_cnt[ROM_AW-1:1];
                    e_din  = {loader_do, loader_do};
                    e_ds   = m_cnt[0] ? 2'b10 : 2'b01;
                end else if (!rom_ce_n && m_f) begin
                    e_rd   = 1'b1;
                    e_addr = rom_addr[ROM_AW-1:1];
                    e_ds   = 2'b11;
                end else if (!wram_ce_n && (!wram_rd_n || !wram_we_n)) begin
                    e_rd   = !wram_rd_n && m_f;
                    e_wr   = !wram_we_n && m_r;
                    e_port = 1'b1;
                    e_addr = {WRAM_BASE_HI, wram_addr[WRAM_AW-1:1]};
                    e_din  = {wram_d, wram_d};
                    e_ds   = wram_addr[0] ? 2'b10 : 2'b01;
                end
                e_bs_rd = !bsram_ce_n && m_f
                          && (!bsram_rd_n || rom_type[7:4] == SA1_TYPE_NIBBLE);
                e_bs_wr = !bsram_ce_n && !bsram_we_n && m_r;
                if (loading && !m_load_r) begin
                    m_cnt = '0;                             // new load starts at zero
                end else if (loader_do_valid) begin
                    m_cnt = m_cnt + 1'b1;
                end
                m_load_r = loading;
                if (!aram_ce_n && !aram_oe_n) begin
                    m_lsb = aram_addr[0];
                end
                m_f  = sysclkf_ce && m_en;                  // old enable
                m_r  = sysclkr_ce && m_en;
                m_en = !sdram_busy && !loader_fail && !frame_sync_pause;
            end
            model_valid = 1'b1;
        end
    end

    initial begin
        seed        = 32'h2933;
        model_valid = 1'b0;
        drive_inputs(0);
        for (int c = 1; c <= STIM_CYCLES; c++) begin
            @(posedge wclk);
            drive_inputs(c);
        end
        repeat (2) @(posedge wclk);                         // last request registered and asserted on
        #10;
        if (i_snes_mem_bridge.i_cpu_port_arbiter.i_req_chk.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "bound request assertions failed");
        end
    end

endmodule

/* verification/snes_mem_bridge_chk.sv */
/* Request strobe checks for the CPU port, bound into cpu_port_arbiter.
   fail_cnt counts failed assertions so the testbench can see them. */

`timescale 1ns/100ps

module snes_mem_bridge_chk (
    input logic       wclk,
    input logic       resetn,
    input logic       rd,
    input logic       wr,
    input logic [1:0] ds
);

    int fail_cnt = 0;

    // one request kind per strobe
    a_rd_wr_excl: assert property (@(posedge wclk) disable iff (!resetn) !(rd && wr))
        else begin
            $error("cpu port rd and wr high in the same cycle");
            fail_cnt++;
        end

    // a strobe always names at least one byte lane
    a_ds_set: assert property (@(posedge wclk) disable iff (!resetn) (rd || wr) |-> ds != 2'b00)
        else begin
            $error("cpu port strobe with no byte lane selected");
            fail_cnt++;
        end

    // synchronous reset, quiet from the edge after
    a_reset_quiet: assert property (@(posedge wclk) !resetn |=> !rd && !wr)
        else begin
            $error("cpu port strobe high during reset");
            fail_cnt++;
        end

endmodule

/* verification/tb_clock_gen.sv */
/* 100 ns wclk from time 0.
   resetn is low for the first 16 rising edges and rises on the 16th. */

`timescale 1ns/100ps

module tb_clock_gen (
    output logic wclk,
    output logic resetn
);

    initial begin
        wclk = 1'b0;
        forever #50 wclk = ~wclk;      // half of 100 ns
    end

    initial begin
        resetn = 1'b0;
        repeat (16) @(posedge wclk);
        resetn <= 1'b1;                 // first edge out of reset is the 17th
    end

endmodule

/* verilog/snes_mem_bridge.sv */
/*
 * SDRAM request bridge between the console core and a dual-port SDRAM controller.
 * Controller, VRAM and core sit outside; only their signals appear here.
 * All strobes are levels and are assumed accepted by the controller.
 */

`timescale 1ns/100ps

module snes_mem_bridge (
    input  logic                                wclk,
    input  logic                                resetn,
    // core timing and run control
    input  logic                                sysclkf_ce,
    input  logic                                sysclkr_ce,
    input  logic                                sdram_busy,
    input  logic                                loader_fail,
    input  logic                                frame_sync_pause,
    output logic                                enable,
    // rom loader
    input  logic                                loading,
    input  logic [7:0]                          loader_do,
    input  logic                                loader_do_valid,
    // rom
    input  logic [snes_mem_pkg::ROM_AW-1:0]     rom_addr,
    input  logic                                rom_ce_n,
    input  logic                                rom_word,
    output logic [15:0]                         rom_q,
    // wram
    input  logic [snes_mem_pkg::WRAM_AW-1:0]    wram_addr,
    input  logic                                wram_ce_n,
    input  logic                                wram_rd_n,
    input  logic                                wram_we_n,
    input  logic [7:0]                          wram_d,
    output logic [7:0]                          wram_q,
    // bsram
    input  logic [7:0]                          rom_type,
    input  logic [snes_mem_pkg::BSRAM_AW-1:0]   bsram_addr,
    input  logic                                bsram_ce_n,
    input  logic                                bsram_rd_n,
    input  logic                                bsram_we_n,
    input  logic [7:0]                          bsram_d,
    output logic [7:0]                          bsram_q,
    // aram
    input  logic [snes_mem_pkg::ARAM_AW-1:0]    aram_addr,
    input  logic                                aram_ce_n,
    input  logic                                aram_oe_n,
    input  logic                                aram_we_n,
    input  logic [7:0]                          aram_d,
    output logic [7:0]                          aram_q,
    // sdram cpu port
    output logic [snes_mem_pkg::ROM_AW-2:0]     sd_cpu_addr,
    output logic [15:0]                         sd_cpu_din,
    output logic [1:0]                          sd_cpu_ds,
    output logic                                sd_cpu_port,
    output logic                                sd_cpu_rd,
    output logic                                sd_cpu_wr,
    input  logic [15:0]                         sd_port0,
    input  logic [15:0]                         sd_port1,
    // sdram bsram port
    output logic [snes_mem_pkg::BSRAM_AW-1:0]   sd_bsram_addr,
    output logic [7:0]                          sd_bsram_din,
    output logic                                sd_bsram_rd,
    output logic                                sd_bsram_wr,
    input  logic [7:0]                          sd_bsram_dout,
    // sdram aram port
    output logic [snes_mem_pkg::ARAM_AW-1:0]    sd_aram_addr,
    output logic [15:0]                         sd_aram_din,
    output logic                                sd_aram_rd,
    output logic                                sd_aram_wr,
    input  logic [15:0]                         sd_aram_dout
);

    logic f_phase;
    logic r_phase;

    sdram_req_if cpu_req ();

    bus_phase_gate i_bus_phase_gate (
        .wclk             (wclk),
        .resetn           (resetn),
        .sysclkf_ce       (sysclkf_ce),
        .sysclkr_ce       (sysclkr_ce),
        .sdram_busy       (sdram_busy),
        .loader_fail      (loader_fail),
        .frame_sync_pause (frame_sync_pause),
        .enable           (enable),
        .f_phase          (f_phase),
        .r_phase          (r_phase)
    );

    cpu_port_arbiter i_cpu_port_arbiter (
        .wclk, .resetn, .f_phase, .r_phase,
        .loading, .loader_do, .loader_do_valid,
        .rom_addr, .rom_ce_n, .rom_word, .rom_q,
        .wram_addr, .wram_ce_n, .wram_rd_n, .wram_we_n, .wram_d, .wram_q,
        .sd_port0, .sd_port1,
        .req              (cpu_req)
    );

    aux_port_ctrl i_aux_port_ctrl (
        .wclk, .resetn, .f_phase, .r_phase, .rom_type,
        .bsram_addr, .bsram_ce_n, .bsram_rd_n, .bsram_we_n, .bsram_d,
        .aram_addr, .aram_ce_n, .aram_oe_n, .aram_we_n, .aram_d, .aram_q,
        .sd_bsram_addr, .sd_bsram_din, .sd_bsram_rd, .sd_bsram_wr,
        .sd_aram_addr, .sd_aram_din, .sd_aram_rd, .sd_aram_wr, .sd_aram_dout
    );

    // controller side of the request bundle
    assign sd_cpu_addr = cpu_req.addr;
    assign sd_cpu_din  = cpu_req.din;
    assign sd_cpu_ds   = cpu_req.ds;
    assign sd_cpu_port = cpu_req.port;
    assign sd_cpu_rd   = cpu_req.rd;
    assign sd_cpu_wr   = cpu_req.wr;

    assign bsram_q = sd_bsram_dout;     // byte-wide already

endmodule

/* verilog/aux_port_ctrl.sv */
/*
 * BSRAM and ARAM ports of the SDRAM controller.
 * BSRAM requests are registered; ARAM strobes are combinational.
 * ARAM is byte-wide, the lane comes from the last read address.
 */

`timescale 1ns/100ps

module aux_port_ctrl (
    input  logic                                wclk,
    input  logic                                resetn,
    input  logic                                f_phase,
    input  logic                                r_phase,
    input  logic [7:0]                          rom_type,       // map control byte
    // bsram bus from the core
    input  logic [snes_mem_pkg::BSRAM_AW-1:0]   bsram_addr,
    input  logic                                bsram_ce_n,
    input  logic                                bsram_rd_n,
    input  logic                                bsram_we_n,
    input  logic [7:0]                          bsram_d,
    // aram bus from the audio core
    input  logic [snes_mem_pkg::ARAM_AW-1:0]    aram_addr,
    input  logic                                aram_ce_n,
    input  logic                                aram_oe_n,
    input  logic                                aram_we_n,
    input  logic [7:0]                          aram_d,
    output logic [7:0]                          aram_q,
    // sdram side
    output logic [snes_mem_pkg::BSRAM_AW-1:0]   sd_bsram_addr,
    output logic [7:0]                          sd_bsram_din,
    output logic                                sd_bsram_rd,
    output logic                                sd_bsram_wr,
    output logic [snes_mem_pkg::ARAM_AW-1:0]    sd_aram_addr,
    output snes_mem_pkg::sdram_word_u           sd_aram_din,
    output logic                                sd_aram_rd,
    output logic                                sd_aram_wr,
    input  snes_mem_pkg::sdram_word_u           sd_aram_dout
);
    import snes_mem_pkg::*;

    logic sa1_cart;
    logic aram_lsb;     // lane of the last aram read

    // sa-1 drives bsram without a read strobe
    assign sa1_cart = (rom_type[7:4] == SA1_TYPE_NIBBLE);

    always_ff @(posedge wclk) begin
        sd_bsram_addr <= bsram_addr;
        sd_bsram_din  <= bsram_d;
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            sd_bsram_rd <= 1'b0;
            sd_bsram_wr <= 1'b0;
        end else begin
            sd_bsram_rd <= ~bsram_ce_n & (~bsram_rd_n | sa1_cart) & f_phase;
            sd_bsram_wr <= ~bsram_ce_n & ~bsram_we_n & r_phase;
        end
    end

    // aram goes straight through, same cycle
    assign sd_aram_addr        = aram_addr;
    assign sd_aram_rd          = ~aram_ce_n & ~aram_oe_n;
    assign sd_aram_wr          = ~aram_ce_n & ~aram_we_n;
    assign sd_aram_din.lane.hi = aram_d;     // ds picks the lane inside the controller
    assign sd_aram_din.lane.lo = aram_d;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            aram_lsb <= 1'b0;
        end else if (sd_aram_rd) begin
            aram_lsb <= aram_addr[0];
        end
    end

    assign aram_q = aram_lsb ? sd_aram_dout.lane.hi : sd_aram_dout.lane.lo;

endmodule

/* verilog/cpu_port_arbiter.sv */
/*
 * CPU port arbiter: loader writes, then ROM reads, then WRAM access.
 * Requests are registered, one edge after the inputs are sampled.
 * The SDRAM must take every strobe; there is no back-pressure.
 */

`timescale 1ns/100ps

module cpu_port_arbiter (
    input  logic                                wclk,
    input  logic                                resetn,
    input  logic                                f_phase,
    input  logic                                r_phase,
    // rom loader byte stream
    input  logic                                loading,
    input  logic [7:0]                          loader_do,
    input  logic                                loader_do_valid,
    // rom bus from the core
    input  logic [snes_mem_pkg::ROM_AW-1:0]     rom_addr,
    input  logic                                rom_ce_n,
    input  logic                                rom_word,
    output snes_mem_pkg::sdram_word_u           rom_q,
    // wram bus from the core
    input  logic [snes_mem_pkg::WRAM_AW-1:0]    wram_addr,
    input  logic                                wram_ce_n,
    input  logic                                wram_rd_n,
    input  logic                                wram_we_n,
    input  logic [7:0]                          wram_d,
    output logic [7:0]                          wram_q,
    // read data back from the controller
    input  snes_mem_pkg::sdram_word_u           sd_port0,
    input  snes_mem_pkg::sdram_word_u           sd_port1,
    sdram_req_if.requester                      req
);
    import snes_mem_pkg::*;

    logic              loading_r;
    logic [ROM_AW-1:0] loader_cnt;     // byte address of the next loader byte
    logic              wram_rd;
    logic              wram_wr;

    logic [ROM_AW-2:0] nxt_addr;
    sdram_word_u       nxt_din;
    logic [1:0]        nxt_ds;
    logic              nxt_port;
    logic              nxt_rd;
    logic              nxt_wr;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    // loader address, restarts on each new load
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r  <= 1'b0;
            loader_cnt <= '0;
        end else begin
            loading_r <= loading;
            if (loading && !loading_r) begin
                loader_cnt <= '0;                       // rising edge of loading
            end else if (loader_do_valid) begin
                loader_cnt <= loader_cnt + ROM_AW'(1);
            end
        end
    end

    // priority mux, idle means everything zero
    always_comb begin
        nxt_addr = '0;
        nxt_din  = '0;
        nxt_ds   = 2'b00;
        nxt_port = 1'b0;
        nxt_rd   = 1'b0;
        nxt_wr   = 1'b0;
        if (loading && loader_do_valid) begin
            nxt_addr        = loader_cnt[ROM_AW-1:1];
            nxt_din.lane.hi = loader_do;                // byte in both lanes
            nxt_din.lane.lo = loader_do;
            nxt_ds          = {loader_cnt[0], ~loader_cnt[0]};
            nxt_wr          = 1'b1;
        end else if (!rom_ce_n && f_phase) begin
            nxt_addr = rom_addr[ROM_AW-1:1];
            nxt_ds   = 2'b11;                           // whole word, lane picked on return
            nxt_rd   = 1'b1;
        end else if (wram_rd || wram_wr) begin
            // EE:0000-EF:FFFF
            nxt_addr        = {WRAM_BASE_HI, wram_addr[WRAM_AW-1:1]};
            nxt_din.lane.hi = wram_d;
            nxt_din.lane.lo = wram_d;
            nxt_ds          = {wram_addr[0], ~wram_addr[0]};
            nxt_port        = 1'b1;
            nxt_rd          = wram_rd & f_phase;        // read strobes on fall
            nxt_wr          = wram_wr & r_phase;        // write strobes on rise
        end
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            req.rd   <= 1'b0;
            req.wr   <= 1'b0;
            req.ds   <= 2'b00;
            req.port <= 1'b0;
        end else begin
            req.rd   <= nxt_rd;
            req.wr   <= nxt_wr;
            req.ds   <= nxt_ds;
            req.port <= nxt_port;
        end
    end

    always_ff @(posedge wclk) begin
        req.addr <= nxt_addr;
        req.din  <= nxt_din;
    end

    // odd byte read of a word fetch, move the high lane down
    always_comb begin
        rom_q = sd_port0;
        if (!rom_word && rom_addr[0]) begin
            rom_q.lane.lo = sd_port0.lane.hi;
            rom_q.lane.hi = sd_port0.lane.lo;
        end
    end

    assign wram_q = wram_addr[0] ? sd_port1.lane.hi : sd_port1.lane.lo;

endmodule

/* verilog/bus_phase_gate.sv */
/*
 * Run gate and phase strobes for the console core.
 * enable follows busy/fail/pause with one edge of delay.
 * f_phase/r_phase lag the core's clock enables by one edge.
 */

`timescale 1ns/100ps

module bus_phase_gate (
    input  logic wclk,
    input  logic resetn,
    input  logic sysclkf_ce,        // core fall phase enable
    input  logic sysclkr_ce,        // core rise phase enable
    input  logic sdram_busy,        // sdram still initializing
    input  logic loader_fail,
    input  logic frame_sync_pause,  // video asks the core to wait
    output logic enable,
    output logic f_phase,
    output logic r_phase
);

    logic run_ok;

    // hold the core until memory is up and nothing asks for a pause
    assign run_ok = ~sdram_busy & ~loader_fail & ~frame_sync_pause;

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
        end else begin
            enable <= run_ok;
        end
    end

    // phase strobes that time every memory request
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            f_phase <= 1'b0;
            r_phase <= 1'b0;
        end else begin
            f_phase <= sysclkf_ce & enable;     // reads go out on this one
            r_phase <= sysclkr_ce & enable;     // wram/bsram writes on this one
        end
    end

endmodule

/* verilog/sdram_req_if.sv */
/*
 * CPU port request bundle toward the dual-port SDRAM controller.
 * Level strobes only, no handshake: one rd or wr pulse is one request.
 */

`timescale 1ns/100ps

interface sdram_req_if;
    import snes_mem_pkg::*;

    logic [ROM_AW-2:0] addr;    // word address, byte bit dropped
    sdram_word_u       din;
    logic [1:0]        ds;      // bit 0 = low byte
    logic              port;    // 1 selects port 1 (wram)
    logic              rd;
    logic              wr;

    // request side, the arbiter
    modport requester (
        output addr, din, ds, port, rd, wr
    );

    // controller side
    modport sdram (
        input addr, din, ds, port, rd, wr
    );

endinterface

/* verilog/snes_mem_pkg.sv */
/*
 * Shared widths and constants for the SDRAM request bridge.
 * SDRAM words are 16 bits with the low byte in lane 0.
 */

package snes_mem_pkg;

    localparam int ROM_AW   = 24;       // snes byte address, also sdram byte address
    localparam int WRAM_AW  = 17;       // 128KB work ram
    localparam int BSRAM_AW = 20;       // battery ram
    localparam int ARAM_AW  = 16;       // 64KB audio ram

    // wram sits at banks EE-EF of the sdram byte space
    localparam logic [ROM_AW-WRAM_AW-1:0] WRAM_BASE_HI = 7'b1110_111;

    // sa-1 style cartridges, bsram reads there ignore the read strobe
    localparam logic [3:0] SA1_TYPE_NIBBLE = 4'hC;

    // one sdram word, seen whole or as two byte lanes
    typedef union packed {
        logic [15:0] word;              // rom word reads, loader, aram write data
        struct packed {
            logic [7:0] hi;             // lane 1, odd byte address
            logic [7:0] lo;             // lane 0, even byte address
        } lane;
    } sdram_word_u;

endpackage
